// ==== Makefile ====
TOP      ?= channel_sum_tb
FLIST    ?= flist.f
LOG      ?= sim.log
VFLAGS   ?= --binary --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
OBJ_DIR  ?= obj_dir

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run into $(LOG), fail on a failing run"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables (override on the command line):"
	@echo "  TOP=$(TOP) FLIST=$(FLIST) LOG=$(LOG)"
	@echo "  VFLAGS=$(VFLAGS)"
	@echo "  SIM_ARGS=$(SIM_ARGS) OBJ_DIR=$(OBJ_DIR)"

test:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	if grep -q "=== FAIL ===" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
	  echo "Simulator exited with status $$status, see $(LOG)"; \
	  exit $$status; \
	fi; \
	echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+include
rtl/channel_sum_pkg.sv
rtl/channel_sum_ctrl.sv
rtl/plane_delay_line.sv
rtl/channel_adder_tree.sv
rtl/channel_sum_top.sv
verification/channel_sum_chk.sv
verification/channel_sum_tb.sv

// ==== include/channel_sum_params.svh ====
`ifndef CHANNEL_SUM_PARAMS_SVH
`define CHANNEL_SUM_PARAMS_SVH

//////////////////////////////
// Stream geometry
//////////////////////////////

// Pixels in one channel plane
`define CS_PLANE_SIZE 16

// Planes summed per group, power of two and at least 2
`define CS_NUM_CH 4

// Sample and sum width
`define CS_DATA_W 16

//////////////////////////////
// Derived counter widths
//////////////////////////////

`define CS_PIX_W $clog2(`CS_PLANE_SIZE)
`define CS_CH_W $clog2(`CS_NUM_CH)

`endif

// ==== rtl/channel_adder_tree.sv ====
`timescale 1ns/1ps
`include "channel_sum_params.svh"

module channel_adder_tree import channel_sum_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     sum_enable,
  input  sample_t [`CS_NUM_CH-1:0] taps,
  output sample_t                  pxl_out,
  output logic                     valid_out
);

  //////////////////////////////
  // Tree geometry
  //////////////////////////////

  localparam int N      = `CS_NUM_CH;
  localparam int LEVELS = `CS_CH_W;
  localparam int NODES  = 2 * N - 1;

  // All tree registers live in one node array.
  // Nodes 0..N-1 are the input register, then each level follows
  // with half the nodes of the one before, ending in the single sum.
  sample_t [NODES-1:0] node_q;

  // One valid per stage, index 0 is the input register
  logic [LEVELS:0] valid_q;

  // Signed add with clamp on overflow
  function automatic sample_t sat_add(input sample_t a, input sample_t b);
    logic signed [`CS_DATA_W:0] wide;
    begin
      wide = a + b;
      // Top two bits differ only when the result left the sample range
      if (wide[`CS_DATA_W] != wide[`CS_DATA_W-1]) begin
        return wide[`CS_DATA_W] ? SAMPLE_MIN : SAMPLE_MAX;
      end
      return wide[`CS_DATA_W-1:0];
    end
  endfunction

  //////////////////////////////
  // Input register
  //////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_in
    always_ff @(posedge clk) begin
      if (sum_enable) begin
        node_q[i] <= taps[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q[0] <= 1'b0;
    end else begin
      valid_q[0] <= sum_enable;
    end
  end

  //////////////////////////////
  // Adder levels
  //////////////////////////////

  for (genvar l = 1; l <= LEVELS; l++) begin : g_level
    // First node of the source and destination levels
    localparam int SRC = 2 * N - ((2 * N) >> (l - 1));
    localparam int DST = 2 * N - ((2 * N) >> l);
    // Number of sums produced here
    localparam int W   = N >> l;

    // Pair node i with node i + W of the level below
    for (genvar i = 0; i < W; i++) begin : g_add
      always_ff @(posedge clk) begin
        if (valid_q[l-1]) begin
          node_q[DST+i] <= sat_add(node_q[SRC+i], node_q[SRC+i+W]);
        end
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        valid_q[l] <= 1'b0;
      end else begin
        valid_q[l] <= valid_q[l-1];
      end
    end
  end

  //////////////////////////////
  // Result
  //////////////////////////////

  assign pxl_out   = node_q[NODES-1];
  assign valid_out = valid_q[LEVELS];

endmodule

// ==== rtl/channel_sum_ctrl.sv ====
`timescale 1ns/1ps
`include "channel_sum_params.svh"

module channel_sum_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid_in,
  output logic [`CS_PIX_W-1:0] pixel_idx,
  output logic                 sum_enable
);

  //////////////////////////////
  // Wrap points
  //////////////////////////////

  localparam logic [`CS_PIX_W-1:0] PIX_LAST = (`CS_PIX_W)'(`CS_PLANE_SIZE - 1);
  localparam logic [`CS_CH_W-1:0]  CH_LAST  = (`CS_CH_W)'(`CS_NUM_CH - 1);

  // Position inside the current plane
  logic [`CS_PIX_W-1:0] pix_cnt;
  // Plane number inside the current group
  logic [`CS_CH_W-1:0]  ch_cnt;

  logic pix_wrap;
  logic ch_wrap;

  assign pix_wrap = (pix_cnt == PIX_LAST);
  assign ch_wrap  = (ch_cnt == CH_LAST);

  //////////////////////////////
  // Counters
  //////////////////////////////

  // Both counters only move on accepted samples, gaps hold them
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
      ch_cnt  <= '0;
    end else if (valid_in) begin
      if (pix_wrap) begin
        pix_cnt <= '0;
        // End of a plane, step to the next channel
        if (ch_wrap) begin
          ch_cnt <= '0;
        end else begin
          ch_cnt <= ch_cnt + 1'b1;
        end
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Shared delay-line address for the current sample
  assign pixel_idx = pix_cnt;

  // Current sample sits in the last plane of its group
  assign sum_enable = valid_in && ch_wrap;

endmodule

// ==== rtl/channel_sum_pkg.sv ====
`include "channel_sum_params.svh"

package channel_sum_pkg;

  //////////////////////////////
  // Sample type
  //////////////////////////////

  // Signed two's complement partial result
  typedef logic signed [`CS_DATA_W-1:0] sample_t;

  //////////////////////////////
  // Saturation limits
  //////////////////////////////

  // Largest positive value, 0111...1
  localparam sample_t SAMPLE_MAX = {1'b0, {(`CS_DATA_W-1){1'b1}}};

  // Most negative value, 1000...0
  localparam sample_t SAMPLE_MIN = {1'b1, {(`CS_DATA_W-1){1'b0}}};

endpackage

// ==== rtl/channel_sum_top.sv ====
`timescale 1ns/1ps
`include "channel_sum_params.svh"

module channel_sum_top import channel_sum_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    valid_in,
  input  sample_t pxl_in,
  output sample_t pxl_out,
  output logic    valid_out
);

  //////////////////////////////
  // Internal wiring
  //////////////////////////////

  logic [`CS_PIX_W-1:0]     pixel_idx;
  logic                     sum_enable;
  // Aligned samples of the current group, tap 0 is the live one
  sample_t [`CS_NUM_CH-1:0] taps;

  //////////////////////////////
  // Control
  //////////////////////////////

  channel_sum_ctrl channel_sum_ctrl_inst (
    .clk        (clk),
    .reset      (reset),
    .valid_in   (valid_in),
    .pixel_idx  (pixel_idx),
    .sum_enable (sum_enable)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  plane_delay_line plane_delay_line_inst (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .pixel_idx (pixel_idx),
    .taps      (taps)
  );

  // Only samples of a group's last plane enter the tree
  channel_adder_tree channel_adder_tree_inst (
    .clk        (clk),
    .reset      (reset),
    .sum_enable (sum_enable),
    .taps       (taps),
    .pxl_out    (pxl_out),
    .valid_out  (valid_out)
  );

endmodule

// ==== rtl/plane_delay_line.sv ====
`timescale 1ns/1ps
`include "channel_sum_params.svh"

module plane_delay_line import channel_sum_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           valid_in,
  input  sample_t                        pxl_in,
  input  logic [`CS_PIX_W-1:0]           pixel_idx,
  output sample_t [`CS_NUM_CH-1:0]       taps
);

  //////////////////////////////
  // Tap 0
  //////////////////////////////

  // The live sample needs no storage
  assign taps[0] = pxl_in;

  //////////////////////////////
  // Plane buffer chain
  //////////////////////////////

  // Stage s holds the plane seen s+1 planes ago. On an accepted sample
  // the old word at pixel_idx leaves as tap s+1, and the word arriving
  // from the stage in front takes its place at the same address.
  for (genvar s = 0; s < `CS_NUM_CH - 1; s++) begin : g_stage
    sample_t plane_mem [`CS_PLANE_SIZE];

    // Combinational read at the shared address
    assign taps[s+1] = plane_mem[pixel_idx];

    // Writes are held off while in reset so the counters and
    // buffer contents restart together
    always_ff @(posedge clk) begin
      if (valid_in && !reset) begin
        plane_mem[pixel_idx] <= taps[s];
      end
    end
  end

endmodule

// ==== verification/channel_sum_chk.sv ====
`timescale 1ns/1ps
`include "channel_sum_params.svh"

module channel_sum_chk (
  input logic clk,
  input logic reset,
  input logic sum_enable,
  input logic valid_out
);

  // Edges from an accepted last-plane sample to a visible sum
  localparam int LAT = `CS_CH_W + 1;

  // Read by the testbench at the end of the run
  int fail_cnt = 0;

  //////////////////////////////
  // Reset behaviour
  //////////////////////////////

  // Output quiet during reset and one cycle after it
  assert property (@(posedge clk) (reset || $past(reset)) |=> !valid_out)
    else begin
      fail_cnt++;
      $error("valid_out high during reset or in the cycle after it");
    end

  //////////////////////////////
  // Valid timing
  //////////////////////////////

  assert property (@(posedge clk) disable iff (reset) sum_enable |-> ##LAT valid_out)
    else begin
      fail_cnt++;
      $error("sum_enable not followed by valid_out at the fixed latency");
    end

  // Every result traces back to an enable
  assert property (@(posedge clk) disable iff (reset) valid_out |-> $past(sum_enable, LAT))
    else begin
      fail_cnt++;
      $error("valid_out high without a matching earlier sum_enable");
    end

endmodule

bind channel_sum_top channel_sum_chk channel_sum_chk_inst (
  .clk        (clk),
  .reset      (reset),
  .sum_enable (sum_enable),
  .valid_out  (valid_out)
);

// ==== verification/channel_sum_tb.sv ====
`timescale 1ns/1ps
`include "channel_sum_params.svh"

module channel_sum_tb import channel_sum_pkg::*; ();

  localparam int  PLANE  = `CS_PLANE_SIZE;
  localparam int  N      = `CS_NUM_CH;
  localparam int  GROUP  = PLANE * N;
  localparam real PERIOD = 40.0;
  // Twelve worst-case groups (gapped ones count twice) plus idle time
  localparam int  TOTAL_CYCLES = GROUP * 12 + 100;

  logic    clk;
  logic    reset;
  logic    valid_in;
  sample_t pxl_in;
  sample_t pxl_out;
  logic    valid_out;

  integer  seed = 32'h7c01;

  // Reference model state
  sample_t sample_q [$];
  sample_t exp_q [$];
  int      pix_cnt;
  int      plane_cnt;
  string   cur_test = "reset";
  int      errors = 0;
  int      checks = 0;
  int      out_count = 0;
  int      run_len = 0;
  int      max_run = 0;

  channel_sum_top channel_sum_top_inst (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .pxl_out   (pxl_out),
    .valid_out (valid_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    repeat (TOTAL_CYCLES * 2 + 200) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles",
             TOTAL_CYCLES * 2 + 200);
    $display("=== FAIL ===");
    $finish;
  end

  //////////////////////////////
  // Reference and helpers
  //////////////////////////////

  // Tap i pairs with tap i+half at each level, clamped per add
  function automatic sample_t ref_group_sum(input sample_t grp [`CS_NUM_CH]);
    sample_t lvl [`CS_NUM_CH];
    longint  wide;
    int      w;
    begin
      lvl = grp;
      w = N / 2;
      while (w >= 1) begin
        for (int i = 0; i < w; i++) begin
          wide = longint'(lvl[i]) + longint'(lvl[i + w]);
          if (wide > longint'(SAMPLE_MAX)) begin
            lvl[i] = SAMPLE_MAX;
          end else if (wide < longint'(SAMPLE_MIN)) begin
            lvl[i] = SAMPLE_MIN;
          end else begin
            lvl[i] = sample_t'(wide);
          end
        end
        w = w / 2;
      end
      return lvl[0];
    end
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    begin
      checks++;
      if (expected != actual) begin
        errors++;
        $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      end
    end
  endtask

  // Drive one cycle and track accepted samples in the model
  task automatic drive_sample(input logic v, input sample_t d);
    sample_t grp [`CS_NUM_CH];
    begin
      @(posedge clk);
      #2;
      valid_in = v;
      pxl_in = d;
      if (v) begin
        sample_q.push_back(d);
        if (plane_cnt == N - 1) begin
          for (int k = 0; k < N; k++) begin
            grp[k] = sample_q[sample_q.size() - 1 - k * PLANE];
          end
          exp_q.push_back(ref_group_sum(grp));
        end
        if (pix_cnt == PLANE - 1) begin
          pix_cnt = 0;
          plane_cnt = (plane_cnt + 1) % N;
        end else begin
          pix_cnt++;
        end
      end
    end
  endtask

  task automatic apply_reset();
    begin
      @(posedge clk);
      #2;
      reset = 1'b1;
      valid_in = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
      // Earlier planes are forgotten, next group starts at channel 0
      sample_q.delete();
      pix_cnt = 0;
      plane_cnt = 0;
      // Sums still in the tree when reset hit never come out
      exp_q.delete();
    end
  endtask

  task automatic wait_drain();
    begin
      drive_sample(1'b0, '0);
      while (exp_q.size() != 0) begin
        @(posedge clk);
      end
      repeat (2) @(posedge clk);
    end
  endtask

  //////////////////////////////
  // Comparing process
  //////////////////////////////

  initial begin
    forever begin
      @(negedge clk);
      if (valid_out === 1'b1) begin
        out_count++;
        run_len++;
        if (run_len > max_run) begin
          max_run = run_len;
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error in %s: valid_out high with no sum expected at %0t",
                   cur_test, $time);
        end else begin
          check_value(cur_test, int'(exp_q.pop_front()), int'(pxl_out));
        end
      end else begin
        run_len = 0;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    sample_t v;
    int      start_count;
    int      assert_fails;
    reset = 1'b1;
    valid_in = 1'b0;
    pxl_in = '0;
    apply_reset();

    cur_test = "basic_group";
    for (int p = 0; p < N; p++) begin
      for (int i = 0; i < PLANE; i++) begin
        drive_sample(1'b1, sample_t'(p + 1));
      end
    end
    wait_drain();

    // Gap cycles carry junk data that must be ignored
    cur_test = "random_gaps";
    for (int i = 0; i < 2 * GROUP; i++) begin
      if ($random(seed) & 1) begin
        drive_sample(1'b0, sample_t'($random(seed)));
      end
      drive_sample(1'b1, sample_t'($random(seed) % 2000));
    end
    wait_drain();

    cur_test = "saturation";
    for (int p = 0; p < N; p++) begin
      for (int i = 0; i < PLANE; i++) begin
        case (i % 3)
          0: v = SAMPLE_MAX - sample_t'(p);
          1: v = SAMPLE_MIN + sample_t'(p);
          default: v = (p < N / 2) ? SAMPLE_MAX : SAMPLE_MIN;
        endcase
        drive_sample(1'b1, v);
      end
    end
    wait_drain();

    cur_test = "streaming";
    start_count = out_count;
    for (int p = 0; p < 3 * N; p++) begin
      for (int i = 0; i < PLANE; i++) begin
        drive_sample(1'b1, sample_t'((p * 37 + i * 5) % 300 - 150));
      end
    end
    wait_drain();
    check_value("stream_count", 3 * PLANE, out_count - start_count);

    // Reset lands halfway through the last plane, with sums in the tree
    cur_test = "reset_mid_group";
    for (int i = 0; i < GROUP - PLANE / 2; i++) begin
      drive_sample(1'b1, sample_t'(1000 + i));
    end
    apply_reset();
    for (int p = 0; p < N; p++) begin
      for (int i = 0; i < PLANE; i++) begin
        drive_sample(1'b1, sample_t'(p * 10 + i));
      end
    end
    wait_drain();

    cur_test = "throughput";
    max_run = 0;
    for (int p = 0; p < N; p++) begin
      for (int i = 0; i < PLANE; i++) begin
        drive_sample(1'b1, sample_t'(i - p * 3));
      end
    end
    wait_drain();
    check_value("throughput_run", PLANE, max_run);

    if (exp_q.size() != 0) begin
      errors++;
      $display("Error: %0d expected sums never appeared on valid_out", exp_q.size());
    end
    assert_fails = channel_sum_top_inst.channel_sum_chk_inst.fail_cnt;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
